/* rtl/payload_buffer.sv */
// frame payload buffer
module payload_buffer (
	input  logic               clk,
	input  logic               resetn,
	input  logic               byte_valid,
	input  spy_pkg::spi_byte_t byte_in,
	input  logic [5:0]         buf_rd_index,
	output logic [31:0]        buf_rd_data
);
	import spy_pkg::*;

	logic [31:0] mem [buf_words];
	logic [7:0]  lo_addr;   // low address byte of the frame
	logic [7:0]  offset;    // payload offset, runs past the index limit
	logic [7:0]  wr_pos;
	logic        payload;

	assign payload = byte_valid && byte_in.index >= 4'd4;
	assign wr_pos  = lo_addr + offset; // wraps at 256

	always_ff @(posedge clk) begin
		if (!resetn) begin
			offset <= '0;
		end else if (byte_valid && byte_in.first) begin
			offset <= '0;
		end else if (payload) begin
			offset <= offset + 8'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (byte_valid && byte_in.index == 4'd3)
			lo_addr <= byte_in.data;
	end

	// byte lane write, little endian inside the word
	always_ff @(posedge clk) begin
		if (payload)
			mem[wr_pos[7:2]][{wr_pos[1:0], 3'b000} +: 8] <= byte_in.data;
	end

	always_ff @(posedge clk) begin
		buf_rd_data <= mem[buf_rd_index];
	end

endmodule

/* rtl/spi_byte_sampler.sv */
// spi pin sampler
module spi_byte_sampler (
	input  logic               clk,
	input  logic               resetn,
	input  logic               spi_cs_n,
	input  logic               spi_sclk,
	input  logic               spi_di,
	output logic               byte_valid,
	output spy_pkg::spi_byte_t byte_out,
	output logic               frame_end
);
	import spy_pkg::*;

	logic [1:0] cs_sync;
	logic [1:0] sclk_sync;
	logic [1:0] di_sync;
	logic       cs_q;
	logic       sclk_q;
	logic [2:0] bit_cnt;
	logic [6:0] shift;
	logic [3:0] byte_idx;
	logic       sclk_rise;
	logic       cs_rise;
	logic       cs_fall;

	assign sclk_rise = sclk_sync[1] & ~sclk_q & ~cs_sync[1]; // only inside a frame
	assign cs_rise   = cs_sync[1] & ~cs_q;
	assign cs_fall   = ~cs_sync[1] & cs_q;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			cs_sync   <= 2'b11;
			sclk_sync <= 2'b00;
			cs_q      <= 1'b1;
			sclk_q    <= 1'b0;
		end else begin
			cs_sync   <= {cs_sync[0], spi_cs_n};
			sclk_sync <= {sclk_sync[0], spi_sclk};
			cs_q      <= cs_sync[1];   // edge register
			sclk_q    <= sclk_sync[1];
		end
	end

	always_ff @(posedge clk) begin
		di_sync <= {di_sync[0], spi_di}; // same delay as sclk
		if (sclk_rise) begin
			shift <= {shift[5:0], di_sync[1]}; // msb first
			if (bit_cnt == 3'd7) begin
				byte_out.data  <= {shift, di_sync[1]};
				byte_out.index <= byte_idx;
				byte_out.first <= byte_idx == 4'd0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			byte_valid <= 1'b0;
			frame_end  <= 1'b0;
			bit_cnt    <= '0;
			byte_idx   <= '0;
		end else begin
			byte_valid <= 1'b0;
			frame_end  <= cs_rise;
			if (cs_fall) begin
				bit_cnt  <= '0;
				byte_idx <= '0;
			end else if (sclk_rise) begin
				bit_cnt <= bit_cnt + 3'd1;
				if (bit_cnt == 3'd7) begin
					byte_valid <= 1'b1;
					if (byte_idx != 4'hf)
						byte_idx <= byte_idx + 4'd1;
				end
			end
		end
	end

	// host has to keep cs low until the last byte has been seen
	a_byte_in_frame: assert property (@(posedge clk) disable iff (!resetn)
		byte_valid |-> !cs_sync[1]);

endmodule

/* rtl/spi_cmd_decoder.sv */
// flash command decoder
module spi_cmd_decoder (
	input  logic                 clk,
	input  logic                 resetn,
	input  logic                 byte_valid,
	input  spy_pkg::spi_byte_t   byte_in,
	input  logic                 frame_end,
	output logic                 rec_valid,
	output spy_pkg::spi_record_t rec,
	input  logic                 rec_ready
);
	import spy_pkg::*;

	typedef enum logic [1:0] {
		st_idle,
		st_collect,
		st_drop
	} frame_state_t;

	frame_state_t state;
	logic         start_frame;
	logic         addr_byte;

	// opcodes that carry a 24 bit address
	function automatic logic is_addr_op(input logic [7:0] op);
		case (spi_opcode_t'(op))
			op_read, op_fast_read, op_page_program, op_sector_erase:
				is_addr_op = 1'b1;
			op_write_enable, op_read_status:
				is_addr_op = 1'b0;
			default:
				is_addr_op = 1'b0;
		endcase
	endfunction

	assign start_frame = byte_valid && byte_in.first && state == st_idle && !rec_valid;
	assign addr_byte   = rec.addr_valid && byte_in.index >= 4'd1 && byte_in.index <= 4'd3;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state     <= st_idle;
			rec_valid <= 1'b0;
		end else begin
			if (rec_valid && rec_ready)
				rec_valid <= 1'b0;
			case (state)
				st_idle: begin
					if (byte_valid && byte_in.first)
						state <= rec_valid ? st_drop : st_collect; // pending record wins
				end
				st_collect: begin
					if (frame_end) begin
						state     <= st_idle;
						rec_valid <= 1'b1;
					end
				end
				st_drop: begin
					if (frame_end)
						state <= st_idle;
				end
				default: state <= st_idle;
			endcase
		end
	end

	// record is built in place, it only changes while no record is offered
	always_ff @(posedge clk) begin
		if (start_frame) begin
			rec.opcode     <= byte_in.data;
			rec.addr       <= '0;
			rec.len        <= '0;
			rec.addr_valid <= is_addr_op(byte_in.data);
		end else if (byte_valid && state == st_collect) begin
			if (addr_byte)
				rec.addr <= {rec.addr[15:0], byte_in.data};
			else
				rec.len <= rec.len + 12'd1;
		end
	end

	a_rec_stable: assert property (@(posedge clk) disable iff (!resetn)
		rec_valid && !rec_ready |=> $stable(rec));

	a_rec_held: assert property (@(posedge clk) disable iff (!resetn)
		rec_valid && !rec_ready |=> rec_valid);

endmodule

/* rtl/spi_spy_top.sv */
// spi flash spy top level
module spi_spy_top (
	input  logic                clk,
	input  logic                resetn,
	input  logic                spi_cs_n,
	input  logic                spi_sclk,
	input  logic                spi_di,
	input  spy_pkg::iomem_req_t iomem_req,
	output logic                iomem_ready,
	output logic [31:0]         iomem_rdata
);
	import spy_pkg::*;

	// byte stream
	logic        byte_valid;
	spi_byte_t   byte_out;
	logic        frame_end;

	// record handshake
	logic        rec_valid;
	spi_record_t rec;
	logic        rec_ready;

	// buffer readback
	logic [5:0]  buf_rd_index;
	logic [31:0] buf_rd_data;

	spi_byte_sampler u_sampler (
		.clk(clk), .resetn(resetn),
		.spi_cs_n(spi_cs_n), .spi_sclk(spi_sclk), .spi_di(spi_di),
		.byte_valid(byte_valid), .byte_out(byte_out), .frame_end(frame_end)
	);

	spi_cmd_decoder u_decoder (
		.clk(clk), .resetn(resetn),
		.byte_valid(byte_valid), .byte_in(byte_out), .frame_end(frame_end),
		.rec_valid(rec_valid), .rec(rec), .rec_ready(rec_ready)
	);

	payload_buffer u_payload (
		.clk(clk), .resetn(resetn),
		.byte_valid(byte_valid), .byte_in(byte_out),
		.buf_rd_index(buf_rd_index), .buf_rd_data(buf_rd_data)
	);

	spy_regs u_regs (
		.clk(clk), .resetn(resetn),
		.iomem_req(iomem_req), .iomem_ready(iomem_ready), .iomem_rdata(iomem_rdata),
		.rec_valid(rec_valid), .rec(rec), .rec_ready(rec_ready),
		.buf_rd_index(buf_rd_index), .buf_rd_data(buf_rd_data)
	);

endmodule

/* rtl/spy_pkg.sv */
// spi flash spy definitions
package spy_pkg;

	// flash opcodes the decoder knows about
	typedef enum logic [7:0] {
		op_write_enable = 8'h06,
		op_read_status  = 8'h05,
		op_read         = 8'h03,
		op_fast_read    = 8'h0b,
		op_page_program = 8'h02,
		op_sector_erase = 8'h20
	} spi_opcode_t;

	typedef struct packed {
		logic [7:0] data;
		logic [3:0] index; // saturates at 15
		logic       first;
	} spi_byte_t;

	typedef struct packed {
		logic [7:0]  opcode; // raw byte
		logic [23:0] addr;
		logic [11:0] len;    // bytes after opcode and address
		logic        addr_valid;
	} spi_record_t;

	typedef struct packed {
		logic        valid;
		logic [3:0]  wstrb;
		logic [31:0] addr;
		logic [31:0] wdata;
	} iomem_req_t;

	// register offsets inside the iomem page
	localparam logic [19:0] reg_timer  = 20'h00000;
	localparam logic [19:0] reg_cmd    = 20'h00004;
	localparam logic [19:0] reg_addr   = 20'h00008;
	localparam logic [19:0] reg_len    = 20'h0000c;
	localparam logic [19:0] reg_status = 20'h00010;
	localparam logic [19:0] buf_base   = 20'h00100;

	localparam int          buf_words  = 64;
	localparam logic [31:0] bad_read   = 32'hdecafbad;
	localparam logic [11:0] iomem_page = 12'h040; // addr[31:20]

endpackage

/* rtl/spy_regs.sv */
// spy iomem registers
module spy_regs (
	input  logic                 clk,
	input  logic                 resetn,
	input  spy_pkg::iomem_req_t  iomem_req,
	output logic                 iomem_ready,
	output logic [31:0]          iomem_rdata,
	input  logic                 rec_valid,
	input  spy_pkg::spi_record_t rec,
	output logic                 rec_ready,
	output logic [5:0]           buf_rd_index,
	input  logic [31:0]          buf_rd_data
);
	import spy_pkg::*;

	typedef enum logic [1:0] {
		acc_idle,
		acc_wait,
		acc_ack
	} acc_state_t;

	acc_state_t  state;
	logic        sel;
	logic [19:0] offset;
	logic        pop;
	logic        accept;
	logic        full;     // record latch occupied
	spi_record_t held;
	logic [27:0] timer;
	logic [23:0] stamp;
	logic [31:0] rd_value;

	assign sel          = iomem_req.valid && iomem_req.addr[31:20] == iomem_page;
	assign offset       = iomem_req.addr[19:0];
	assign buf_rd_index = offset[7:2];
	assign iomem_ready  = state == acc_ack;

	// popping write to status, taken in the ack cycle
	assign pop = iomem_ready && sel && offset == reg_status &&
		iomem_req.wstrb[0] && iomem_req.wdata[0];

	assign rec_ready = !full || pop;
	assign accept    = rec_valid && rec_ready;

	always_comb begin
		case (offset)
			reg_timer:  rd_value = {4'h0, timer};
			reg_cmd:    rd_value = {stamp, held.opcode};
			reg_addr:   rd_value = {8'h00, held.addr};
			reg_len:    rd_value = {19'h0, held.addr_valid, held.len};
			reg_status: rd_value = {31'h0, full};
			default:    rd_value = (offset >= buf_base) ? buf_rd_data : bad_read;
		endcase
	end

	// idle, wait for the buffer word, then a single ack
	always_ff @(posedge clk) begin
		if (!resetn) begin
			state <= acc_idle;
		end else begin
			case (state)
				acc_idle: if (sel) state <= acc_wait;
				acc_wait: state <= acc_ack;
				acc_ack:  state <= acc_idle;
				default:  state <= acc_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == acc_wait)
			iomem_rdata <= rd_value;
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			timer <= '0;
			full  <= 1'b0;
		end else begin
			timer <= timer + 28'd1;
			if (accept)
				full <= 1'b1;  // a pop and a new record in one cycle keeps it full
			else if (pop)
				full <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			held  <= rec;
			stamp <= timer[27:4]; // coarse timestamp
		end
	end

	a_ready_pulse: assert property (@(posedge clk) disable iff (!resetn)
		iomem_ready |=> !iomem_ready);

endmodule

/* run_sim.sh */
#!/bin/sh
# build and run the spi spy simulation with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module tb_spi_spy -o sim_tb
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

out=$(./obj_dir/sim_tb 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	exit 1
fi
if echo "$out" | grep -qx "Result: PASSED"; then
	exit 0
fi
exit 1

/* tests/spy_testdata.hex */
// one frame per line: opcode, 24 bit address, payload byte count, addr_valid
// frames 2 and 3 go out back to back, frame 3 is dropped
03 000010 08 1
0b 001234 05 1
02 00a040 06 1
20 000080 04 1
02 0000f8 0c 1
06 000000 00 0
05 000000 02 0
03 fffffe 24 1
0b 123456 01 1
02 0000c3 10 1

/* tests/tb_spi_spy.sv */
// spi flash spy testbench
module tb_spi_spy;
	import spy_pkg::*;

	localparam int num_frames  = 10;
	localparam int cycle_limit = num_frames * (40 * 8 * 8 + 200);

	logic        clk;
	logic        resetn;
	logic        spi_cs_n;
	logic        spi_sclk;
	logic        spi_di;
	iomem_req_t  iomem_req;
	logic        iomem_ready;
	logic [31:0] iomem_rdata;

	logic [31:0] td [0:num_frames*4-1]; // opcode, addr, payload count, flag
	integer      seed;
	int          cycles = 0;
	int          f;
	logic [31:0] rd;
	spi_record_t got;

	spi_spy_top u_spi_spy_top (
		.clk(clk), .resetn(resetn),
		.spi_cs_n(spi_cs_n), .spi_sclk(spi_sclk), .spi_di(spi_di),
		.iomem_req(iomem_req), .iomem_ready(iomem_ready), .iomem_rdata(iomem_rdata)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles > cycle_limit) begin
			$display("Timeout: run passed %0d cycles without finishing", cycle_limit);
			$display("Result: FAILED");
			$fatal(1, "timeout");
		end
	end

	task automatic fail_run(input string what);
		$display("%s", what);
		$display("Result: FAILED");
		$fatal(1, "check failed");
	endtask

	task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (act !== exp)
			fail_run($sformatf("Mismatch %s: expected 0x%h, got 0x%h", name, exp, act));
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp)
			fail_run($sformatf("Mismatch %s: expected 0x%h, got 0x%h", name, exp, act));
	endtask

	task automatic check_record(input spi_record_t exp, input spi_record_t act);
		if (act.opcode !== exp.opcode)
			fail_run($sformatf("Mismatch rec.opcode: expected 0x%h, got 0x%h",
				exp.opcode, act.opcode));
		if (act.addr !== exp.addr)
			fail_run($sformatf("Mismatch rec.addr: expected 0x%h, got 0x%h",
				exp.addr, act.addr));
		if (act.len !== exp.len)
			fail_run($sformatf("Mismatch rec.len: expected 0x%h, got 0x%h",
				exp.len, act.len));
		if (act.addr_valid !== exp.addr_valid)
			fail_run($sformatf("Mismatch rec.addr_valid: expected 0x%h, got 0x%h",
				exp.addr_valid, act.addr_valid));
	endtask

	task automatic wait_clks(input int n);
		repeat (n) @(posedge clk);
	endtask

	// one iomem access, request held until the single ready pulse
	task automatic bus_access(input logic [19:0] offs, input logic [3:0] wstrb,
			input logic [31:0] wdata, output logic [31:0] rdata);
		iomem_req_t req;
		int         n;
		req.valid = 1'b1;
		req.wstrb = wstrb;
		req.addr  = {iomem_page, offs};
		req.wdata = wdata;
		n = 0;
		@(posedge clk);
		iomem_req <= req;
		do begin
			@(negedge clk);
			n++;
			if (n > 3)
				fail_run($sformatf("iomem access to offset %h not acknowledged in 2 cycles", offs));
		end while (!iomem_ready);
		rdata = iomem_rdata;
		@(posedge clk);
		iomem_req <= '0;
	endtask

	task automatic reg_read(input logic [19:0] offs, output logic [31:0] data);
		bus_access(offs, 4'h0, 32'h0, data);
	endtask

	task automatic pop_record();
		logic [31:0] unused;
		bus_access(reg_status, 4'hf, 32'h1, unused);
	endtask

	// mode 0, di set while sclk low, half period 4 clk
	task automatic send_byte(input logic [7:0] b);
		for (int i = 7; i >= 0; i--) begin
			spi_di <= b[i];
			wait_clks(4);
			spi_sclk <= 1'b1;
			wait_clks(4);
			spi_sclk <= 1'b0;
		end
	endtask

	function automatic logic [7:0] payload_byte(input logic [23:0] addr,
			input logic [7:0] op, input int k);
		logic [23:0] s;
		s = addr + 24'(k);
		return s[7:0] ^ op;
	endfunction

	// opcode, then the address or three filler bytes, then the payload
	task automatic send_frame(input int idx);
		logic [7:0]  op;
		logic [23:0] addr;
		logic [23:0] lead;
		int          n;
		int          gap;
		op   = td[idx*4][7:0];
		addr = td[idx*4+1][23:0];
		n    = int'(td[idx*4+2]);
		lead = td[idx*4+3][0] ? addr : ~addr; // filler must not look like an address
		@(posedge clk);
		spi_cs_n <= 1'b0;
		wait_clks(4);
		send_byte(op);
		send_byte(lead[23:16]);
		send_byte(lead[15:8]);
		send_byte(lead[7:0]);
		for (int k = 0; k < n; k++)
			send_byte(payload_byte(addr, op, k));
		wait_clks(4);
		spi_cs_n <= 1'b1;
		wait_clks(8); // record lands within 4 cycles
		gap = $unsigned($random(seed)) % 8 + 2;
		wait_clks(gap);
	endtask

	function automatic spi_record_t expected_record(input int idx);
		spi_record_t r;
		int          n;
		n            = int'(td[idx*4+2]);
		r.opcode     = td[idx*4][7:0];
		r.addr_valid = td[idx*4+3][0];
		r.addr       = r.addr_valid ? td[idx*4+1][23:0] : 24'h0;
		r.len        = r.addr_valid ? 12'(n) : 12'(n + 3); // filler bytes count as data
		return r;
	endfunction

	task automatic read_record(output spi_record_t r);
		logic [31:0] v;
		reg_read(reg_cmd, v);
		r.opcode = v[7:0];
		reg_read(reg_addr, v);
		r.addr = v[23:0];
		reg_read(reg_len, v);
		r.len        = v[11:0];
		r.addr_valid = v[12];
	endtask

	task automatic check_payload(input int idx);
		logic [7:0]  op;
		logic [23:0] addr;
		logic [7:0]  pos;
		logic [31:0] v;
		int          n;
		op   = td[idx*4][7:0];
		addr = td[idx*4+1][23:0];
		n    = int'(td[idx*4+2]);
		for (int k = 0; k < n; k++) begin
			pos = addr[7:0] + 8'(k); // wraps inside the buffer
			reg_read(buf_base + {12'h0, pos[7:2], 2'b00}, v);
			check_word("buffer byte", {24'h0, payload_byte(addr, op, k)},
				{24'h0, v[{pos[1:0], 3'b000} +: 8]});
		end
	endtask

	task automatic check_timing();
		logic [31:0] t0;
		logic [31:0] t1;
		logic [31:0] cmd;
		reg_read(reg_timer, t0);
		reg_read(reg_timer, t1);
		if (t1 <= t0)
			fail_run("timer did not advance between two reads");
		reg_read(reg_cmd, cmd);
		reg_read(reg_timer, t1);
		if (cmd[31:8] > t1[27:4])
			fail_run("record timestamp is later than the timer read after it");
	endtask

	initial begin
		seed      = 43443;
		resetn    = 1'b0;
		spi_cs_n  = 1'b1;
		spi_sclk  = 1'b0;
		spi_di    = 1'b0;
		iomem_req = '0;
		$readmemh("tests/spy_testdata.hex", td);
		wait_clks(10);
		resetn <= 1'b1;
		wait_clks(2);

		reg_read(reg_status, rd);
		check_flag("status.pending", 1'b0, rd[0]);
		reg_read(20'h00020, rd);
		check_word("unmapped read", 32'hdecafbad, rd);

		f = 0;
		while (f < num_frames) begin
			send_frame(f);
			reg_read(reg_status, rd);
			check_flag("status.pending", 1'b1, rd[0]);
			read_record(got);
			check_record(expected_record(f), got);
			if (td[f*4+3][0])
				check_payload(f);
			check_timing();
			if (f == 1) begin
				// frame 2 waits in the decoder, frame 3 is dropped
				send_frame(2);
				send_frame(3);
				pop_record();
				reg_read(reg_status, rd);
				check_flag("status.pending", 1'b1, rd[0]);
				read_record(got);
				check_record(expected_record(2), got);
				check_payload(2);
				check_payload(3); // dropped frame still lands in the buffer
				f = 3;
			end
			pop_record();
			reg_read(reg_status, rd);
			check_flag("status.pending", 1'b0, rd[0]);
			f++;
		end

		$display("Result: PASSED");
		$finish;
	end

endmodule

/* verilog.f */
rtl/spy_pkg.sv
rtl/spi_byte_sampler.sv
rtl/spi_cmd_decoder.sv
rtl/payload_buffer.sv
rtl/spy_regs.sv
rtl/spi_spy_top.sv
tests/tb_spi_spy.sv
